//--- chipsetBridge.f
logic/chipsetBridgePkg.sv
logic/colorClockSync.sv
logic/registerSpaceDecode.sv
logic/chipBusCycle.sv
logic/chipDataLatch.sv
logic/chipsetBridge.sv
testbench/chipsetBridge_sva.sv
testbench/chipsetBridgeTb.sv

//--- logic/chipBusCycle.sv
////////////////////////////////////////
// MC68000 style bus cycle sequencer for register accesses
// Runs one cycle at a time off the colour clock state strobes
// Agnus wait states are taken at state 4
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module chipBusCycle
    import chipsetBridgePkg::*;
(
    input  wire  CLK40,
    input  wire  nRESET,
    input  wire  phaseS2,           // 68000 state strobes
    input  wire  phaseS4,
    input  wire  phaseS5,
    input  wire  phaseS7,
    input  wire  regReq,            // Decoded register request
    input  wire  rnw,
    input  wire  upperLane,
    input  wire  lowerLane,
    input  wire  nDBR,              // Agnus owns the bus when low
    input  wire  casAgnus,          // Agnus chip RAM access in progress
    output logic nAS,
    output logic nUDS,
    output logic nLDS,
    output logic nRegEn,            // Register space enable to the chips
    output logic regTa,             // Transfer acknowledge to the CPU
    output logic regCycle,          // Bridge busy with register cycles
    output logic readLatch,         // Capture chip read data now
    output logic writeCycle         // Write data should be driven
);

    logic [2:0] state;
    logic       asOn;               // Address strobe active
    logic       dsOn;               // Data strobes allowed
    logic       udsOn, ldsOn;       // Lanes captured at cycle start
    logic       regEnOn;
    logic       taOn;
    logic       cycleOn;
    logic       readCyc;            // rnw held for the whole cycle

    ////////////////////////////////////////
    // Bus outputs

    assign nAS      = ~asOn;
    assign nUDS     = ~(udsOn & dsOn);
    assign nLDS     = ~(ldsOn & dsOn);
    assign nRegEn   = ~regEnOn;
    assign regTa    = taOn;
    assign regCycle = cycleOn;

    // Same edge as the early read acknowledge
    assign readLatch = (state == ST_S5) & phaseS5 & readCyc;

    ////////////////////////////////////////
    // Sequencer

    always_ff @(posedge CLK40) begin
        if (!nRESET) begin
            state      <= ST_S2;
            asOn       <= 1'b0;
            dsOn       <= 1'b0;
            udsOn      <= 1'b0;
            ldsOn      <= 1'b0;
            regEnOn    <= 1'b0;
            taOn       <= 1'b0;
            cycleOn    <= 1'b0;
            readCyc    <= 1'b1;
            writeCycle <= 1'b0;
        end else begin
            taOn <= 1'b0;                           // Acknowledge lasts one clock

            case (state)
                ST_S2: begin
                    if (phaseS2) begin
                        if (regReq) begin
                            asOn       <= 1'b1;
                            regEnOn    <= 1'b1;
                            cycleOn    <= 1'b1;
                            udsOn      <= upperLane;
                            ldsOn      <= lowerLane;
                            dsOn       <= rnw;      // Reads strobe with AS
                            readCyc    <= rnw;
                            writeCycle <= ~rnw;
                            state      <= ST_S4;
                        end else begin
                            cycleOn <= 1'b0;        // No follow-on access
                        end
                    end
                end

                ST_S4: begin
                    // Write strobes go out once data is on the bus
                    if (phaseS4) begin
                        dsOn <= 1'b1;
                        if (nDBR && !casAgnus) begin
                            state <= ST_S5;
                        end                         // Else one more colour clock
                    end
                end

                ST_S5: begin
                    if (phaseS5) begin
                        taOn  <= readCyc;           // Reads finish early
                        state <= ST_S6;
                    end
                end

                ST_S6: begin
                    if (phaseS2) begin
                        state <= ST_S7;
                    end
                end

                ST_S7: begin
                    // Strobes released, writes acknowledged here
                    if (phaseS7) begin
                        asOn       <= 1'b0;
                        dsOn       <= 1'b0;
                        regEnOn    <= 1'b0;
                        writeCycle <= 1'b0;
                        taOn       <= ~readCyc;
                        state      <= ST_S2;
                    end
                end

                default: begin
                    state <= ST_S2;                 // Recover from a bad code
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/chipDataLatch.sv
////////////////////////////////////////
// Data path between the CPU and the chip data bus
// Holds read data for the CPU and write data for the chips
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module chipDataLatch
    import chipsetBridgePkg::*;
(
    input  wire              CLK40,
    input  wire              nRESET,
    input  wire              readLatch,     // One clock pulse at state 5
    input  wire              writeCycle,    // High through a write cycle
    input  wire [DATA_W-1:0] chipDataIn,
    input  wire [DATA_W-1:0] cpuWriteData,
    output logic [DATA_W-1:0] cpuReadData,
    output logic [DATA_W-1:0] chipDataOut,
    output logic             chipDataOe     // Enable for the chip bus drivers
);

    logic writeStart;

    // First clock of a write, the enable is not up yet
    assign writeStart = writeCycle & ~chipDataOe;

    ////////////////////////////////////////
    // Read path

    // Held until the next read overwrites it
    always_ff @(posedge CLK40) begin
        if (readLatch) begin
            cpuReadData <= chipDataIn;
        end
    end

    ////////////////////////////////////////
    // Write path

    always_ff @(posedge CLK40) begin
        if (writeStart) begin
            chipDataOut <= cpuWriteData;        // Frozen for the whole cycle
        end
    end

    // Follows writeCycle one clock late
    always_ff @(posedge CLK40) begin
        if (!nRESET) begin
            chipDataOe <= 1'b0;
        end else begin
            chipDataOe <= writeCycle;
        end
    end

endmodule

`default_nettype wire

//--- logic/chipsetBridge.sv
////////////////////////////////////////
// Top of the CPU to custom chip register bridge
// Turns CPU accesses into 68000 cycles on the chip bus
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module chipsetBridge
    import chipsetBridgePkg::*;
(
    input  wire               CLK40,
    input  wire               nRESET,
    input  wire               C1,
    input  wire               C3,
    input  wire               cpuCycle,
    input  wire  [ADDR_W-1:0] cpuAddr,
    input  wire               rnw,
    input  wire  [1:0]        siz,
    input  wire  [DATA_W-1:0] cpuWriteData,
    input  wire               nDBR,
    input  wire               casAgnus,
    input  wire  [DATA_W-1:0] chipDataIn,
    output logic [DATA_W-1:0] cpuReadData,
    output logic [DATA_W-1:0] chipDataOut,
    output logic              chipDataOe,
    output logic              nAS,
    output logic              nUDS,
    output logic              nLDS,
    output logic              nRegEn,
    output logic              regTa,
    output logic              regCycle
);

    logic phaseS2, phaseS4, phaseS5, phaseS7;   // State strobes
    logic regReq, upperLane, lowerLane;         // Decode results
    logic readLatch, writeCycle;                // Sequencer to data path

    colorClockSync colorClockSync_i (
        .CLK40   (CLK40),
        .nRESET  (nRESET),
        .C1      (C1),
        .C3      (C3),
        .phaseS2 (phaseS2),
        .phaseS4 (phaseS4),
        .phaseS5 (phaseS5),
        .phaseS7 (phaseS7)
    );

    registerSpaceDecode registerSpaceDecode_i (
        .cpuCycle  (cpuCycle),
        .cpuAddr   (cpuAddr),
        .rnw       (rnw),
        .siz       (siz),
        .regReq    (regReq),
        .upperLane (upperLane),
        .lowerLane (lowerLane)
    );

    chipBusCycle chipBusCycle_i (
        .CLK40      (CLK40),
        .nRESET     (nRESET),
        .phaseS2    (phaseS2),
        .phaseS4    (phaseS4),
        .phaseS5    (phaseS5),
        .phaseS7    (phaseS7),
        .regReq     (regReq),
        .rnw        (rnw),
        .upperLane  (upperLane),
        .lowerLane  (lowerLane),
        .nDBR       (nDBR),
        .casAgnus   (casAgnus),
        .nAS        (nAS),
        .nUDS       (nUDS),
        .nLDS       (nLDS),
        .nRegEn     (nRegEn),
        .regTa      (regTa),
        .regCycle   (regCycle),
        .readLatch  (readLatch),
        .writeCycle (writeCycle)
    );

    chipDataLatch chipDataLatch_i (
        .CLK40        (CLK40),
        .nRESET       (nRESET),
        .readLatch    (readLatch),
        .writeCycle   (writeCycle),
        .chipDataIn   (chipDataIn),
        .cpuWriteData (cpuWriteData),
        .cpuReadData  (cpuReadData),
        .chipDataOut  (chipDataOut),
        .chipDataOe   (chipDataOe)
    );

endmodule

`default_nettype wire

//--- logic/chipsetBridgePkg.sv
////////////////////////////////////////
// Constants shared by the chipset register bridge
// Bus widths, the custom chip window, the SIZ codes
// and the 68000 state codes of the bus sequencer
////////////////////////////////////////
`default_nettype none

package chipsetBridgePkg;

    ////////////////////////////////////////
    // Bus widths

    localparam int ADDR_W = 24;                     // CPU address A23..A0
    localparam int DATA_W = 16;                     // Chip data bus D15..D0

    ////////////////////////////////////////
    // Address decode

    // Top 12 address bits of the custom chip window
    localparam logic [11:0] REG_SPACE_BASE = 12'hDFF;

    // Transfer size as SIZ1:SIZ0
    localparam logic [1:0] SIZ_BYTE = 2'b01;        // Single byte
    localparam logic [1:0] SIZ_WORD = 2'b10;        // Full 16 bit word

    ////////////////////////////////////////
    // Bus sequencer states

    // Named after the MC68000 bus states they stand for
    localparam logic [2:0] ST_S2 = 3'd0;            // Idle, waiting for a request
    localparam logic [2:0] ST_S4 = 3'd1;            // Strobes out, Agnus may hold off
    localparam logic [2:0] ST_S5 = 3'd2;            // Early read acknowledge
    localparam logic [2:0] ST_S6 = 3'd3;            // Data phase
    localparam logic [2:0] ST_S7 = 3'd4;            // Close of cycle

endpackage

`default_nettype wire

//--- logic/colorClockSync.sv
////////////////////////////////////////
// Brings the C1 and C3 colour clocks into the CLK40 domain
// Each output is a one cycle strobe that marks a 68000 state
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module colorClockSync (
    input  wire  CLK40,
    input  wire  nRESET,
    input  wire  C1,                // Colour clock, leads C3 by 90 degrees
    input  wire  C3,
    output logic phaseS2,           // C3 fell, C1 low
    output logic phaseS4,           // C3 rose, C1 high
    output logic phaseS5,           // C1 fell, C3 high
    output logic phaseS7            // C1 rose, C3 low
);

    logic [2:0] c1Hist;             // Bit 0 is the newest sample
    logic [2:0] c3Hist;
    logic c1Rise, c1Fall;
    logic c3Rise, c3Fall;

    ////////////////////////////////////////
    // Pin history

    always_ff @(posedge CLK40) begin
        if (!nRESET) begin
            c1Hist <= 3'b111;
            c3Hist <= 3'b111;
        end else begin
            c1Hist <= {c1Hist[1:0], C1};
            c3Hist <= {c3Hist[1:0], C3};
        end
    end

    // Edges are taken from the two settled stages only
    // Stage 0 may still be metastable and is never decoded
    assign c1Rise = c1Hist[1] & ~c1Hist[2];
    assign c1Fall = ~c1Hist[1] & c1Hist[2];
    assign c3Rise = c3Hist[1] & ~c3Hist[2];
    assign c3Fall = ~c3Hist[1] & c3Hist[2];

    ////////////////////////////////////////
    // State strobes

    // Registered, so a strobe appears three edges after the pin edge
    always_ff @(posedge CLK40) begin
        if (!nRESET) begin
            phaseS2 <= 1'b0;
            phaseS4 <= 1'b0;
            phaseS5 <= 1'b0;
            phaseS7 <= 1'b0;
        end else begin
            phaseS2 <= c3Fall & ~c1Hist[1];     // Both clocks now low
            phaseS4 <= c3Rise & c1Hist[1];      // Both clocks now high
            phaseS5 <= c1Fall & c3Hist[1];
            phaseS7 <= c1Rise & ~c3Hist[1];
        end
    end

endmodule

`default_nettype wire

//--- logic/registerSpaceDecode.sv
////////////////////////////////////////
// Qualifies a CPU access as a custom chip register cycle
// and works out which byte lanes the 68000 strobes drive
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module registerSpaceDecode
    import chipsetBridgePkg::*;
(
    input  wire              cpuCycle,      // CPU has an access pending
    input  wire [ADDR_W-1:0] cpuAddr,
    input  wire              rnw,           // High for a read
    input  wire [1:0]        siz,           // SIZ1:SIZ0
    output logic             regReq,        // Access falls in register space
    output logic             upperLane,     // Drive UDS, D15..D8
    output logic             lowerLane      // Drive LDS, D7..D0
);

    localparam int WIN_W = $bits(REG_SPACE_BASE);

    logic inWindow;
    logic byteAccess;

    ////////////////////////////////////////
    // Address window

    // Only the top bits matter, registers are decoded by the chips
    assign inWindow = (cpuAddr[ADDR_W-1 -: WIN_W] == REG_SPACE_BASE);
    assign regReq   = cpuCycle & inWindow;

    ////////////////////////////////////////
    // Byte lanes

    // Long and three byte codes never reach here as a single cycle
    // so anything wider than a byte uses both lanes
    always_comb begin
        case (siz)
            SIZ_BYTE: byteAccess = 1'b1;
            SIZ_WORD: byteAccess = 1'b0;
            default:  byteAccess = 1'b0;    // Treat as word
        endcase
    end

    // Reads always fetch the whole word
    // Even address is the upper byte on the 68000
    assign upperLane = rnw | ~cpuAddr[0];

    // Odd byte or any word write needs the low lane
    assign lowerLane = rnw | cpuAddr[0] | ~byteAccess;

endmodule

`default_nettype wire

//--- runSim.sh
#!/bin/bash
# Builds the chipset bridge testbench with Verilator and runs it
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module chipsetBridgeTb \
    -f chipsetBridge.f \
    -o simChipsetBridge

./obj_dir/simChipsetBridge 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

//--- testbench/chipsetBridgeTb.sv
////////////////////////////////////////
// Testbench for the chipset register bridge
// Replays the golden access list through a CPU and Agnus model
// and checks strobes, acknowledge and data on every access
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module chipsetBridgeTb;

    logic        CLK40 = 1'b0;
    logic        nRESET;
    logic        C1, C3;                    // Colour clocks, C1 leads C3
    logic        cpuCycle, rnw;
    logic [23:0] cpuAddr;
    logic [1:0]  siz;
    logic [15:0] cpuWriteData;
    logic        nDBR, casAgnus;            // Agnus model levels
    logic [15:0] chipDataIn;
    wire  [15:0] cpuReadData, chipDataOut;
    wire         chipDataOe, nAS, nUDS, nLDS, nRegEn, regTa, regCycle;

    logic        vecRnw[$];                 // Golden vectors
    logic [23:0] vecAddr[$];
    logic [1:0]  vecSiz[$];
    logic [15:0] vecWrite[$];
    int          vecHolds[$];
    logic [15:0] vecChip[$];
    logic        vecUds[$], vecLds[$];      // Both high means no bus cycle
    logic [15:0] vecRead[$];

    int phase;                  // CLK40 count within a colour clock
    int holdLeft;               // C1 rises left before nDBR is released
    int checks;
    int errors;
    int watchdogNs;

    chipsetBridge chipsetBridge_i (.*);

    always #5 CLK40 = ~CLK40;   // 10 ns period

    ////////////////////////////////////////
    // Watchdog

    initial begin
        wait (watchdogNs > 0);
        #(watchdogNs);
        $display("Watchdog expired after %0d ns, the accesses did not finish", watchdogNs);
        $display("STATUS: FAIL");
        $finish;
    end

    // One CLK40 cycle, all inputs move 1 ns after the edge
    task automatic nextCycle();
        @(posedge CLK40);
        #1;
        phase = (phase + 1) % 28;
        C1 = (phase < 14);
        C3 = (phase >= 7) && (phase < 21);      // A quarter period behind C1
        if (phase == 0 && holdLeft > 0) begin   // C1 rising edge
            holdLeft = holdLeft - 1;
            nDBR = (holdLeft == 0);
        end
    endtask

    task automatic reportMismatch(input string testName, input logic [15:0] expected,
                                  input logic [15:0] actual);
        errors = errors + 1;
        $display("FAILED %s: expected %h, actual %h", testName, expected, actual);
    endtask

    task automatic reportProblem(input string what);
        errors = errors + 1;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic checkIdleLevels(input string testName);
        checks = checks + 1;
        if ({nAS, nUDS, nLDS, nRegEn} !== 4'b1111) begin
            reportMismatch({testName, " strobes"}, 16'h000f, {12'h0, nAS, nUDS, nLDS, nRegEn});
        end
        checks = checks + 1;
        if ({regTa, regCycle, chipDataOe} !== 3'b000) begin
            reportMismatch({testName, " status"}, 16'h0000, {13'h0, regTa, regCycle, chipDataOe});
        end
    endtask

    ////////////////////////////////////////
    // Golden file

    task automatic readGolden();
        int fd, code, h;
        string line;
        logic r, u, l;
        logic [23:0] a;
        logic [1:0] s;
        logic [15:0] w, c, d;
        fd = $fopen("testbench/chipsetBridge_golden.txt", "r");
        if (fd == 0) begin
            reportProblem("cannot open the golden vector file");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%h %h %h %h %d %h %h %h %h", r, a, s, w, h, c, u, l, d);
                if (code == 9) begin
                    vecRnw.push_back(r);
                    vecAddr.push_back(a);
                    vecSiz.push_back(s);
                    vecWrite.push_back(w);
                    vecHolds.push_back(h);
                    vecChip.push_back(c);
                    vecUds.push_back(u);
                    vecLds.push_back(l);
                    vecRead.push_back(d);
                end else if ($fgets(line, fd) == 0) begin  // Skip a comment line
                    break;
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////
    // One CPU access

    task automatic runAccess(input int i);
        logic isRead, isMiss, taSeen, prevNas, strobeSeen, gotUds, gotLds;
        logic oeSeen, oeBad, quiet;
        logic [15:0] oeValue;
        int n, gap, limit;
        string tag;
        tag = $sformatf("vector %0d", i);
        gap = $urandom % 16;                    // Idle CLK40 cycles before the access
        for (n = 0; n < gap; n++) begin
            nextCycle();
        end
        isRead = vecRnw[i];
        isMiss = vecUds[i] && vecLds[i];
        cpuCycle = 1'b1;
        rnw = isRead;
        cpuAddr = vecAddr[i];
        siz = vecSiz[i];
        cpuWriteData = vecWrite[i];
        chipDataIn = vecChip[i];                // What the chips return
        holdLeft = vecHolds[i];
        nDBR = (holdLeft == 0);
        {taSeen, strobeSeen, oeSeen, oeBad} = 4'b0000;
        {prevNas, gotUds, gotLds, quiet} = 4'b1111;
        oeValue = 16'h0;
        limit = isMiss ? 4 * 28 : (vecHolds[i] + 6) * 28;
        n = 0;
        while (n < limit && !(taSeen && nAS)) begin
            nextCycle();
            n = n + 1;
            if (!nAS && (!nUDS || !nLDS) && !strobeSeen) begin
                strobeSeen = 1'b1;              // First active strobe pattern
                gotUds = nUDS;
                gotLds = nLDS;
            end
            if (chipDataOe) begin
                oeSeen = 1'b1;
                if (chipDataOut !== vecWrite[i]) begin
                    oeBad = 1'b1;
                    oeValue = chipDataOut;
                end
            end
            if (!nAS || !nRegEn) begin
                quiet = 1'b0;
            end
            if (regTa) begin
                if (taSeen) begin
                    reportProblem({tag, ": more than one regTa"});
                end
                taSeen = 1'b1;
                cpuCycle = 1'b0;                // CPU moves on
                checks = checks + 1;
                if (holdLeft != 0) begin
                    reportProblem({tag, ": regTa while Agnus still holds nDBR low"});
                end
                checks = checks + 1;
                if ({prevNas, nAS} !== {1'b0, ~isRead}) begin   // Read in cycle, write at close
                    reportMismatch({tag, " nAS at regTa"}, {15'h0, ~isRead}, {14'h0, prevNas, nAS});
                end
                checks = checks + 1;
                if (nRegEn !== ~isRead) begin       // Enable drops and rises with nAS
                    reportMismatch({tag, " nRegEn at regTa"}, {15'h0, ~isRead}, {15'h0, nRegEn});
                end
                checks = checks + 1;
                if (regCycle !== 1'b1) begin        // Busy through the whole access
                    reportMismatch({tag, " regCycle at regTa"}, 16'h0001, {15'h0, regCycle});
                end
            end
            prevNas = nAS;
        end
        cpuCycle = 1'b0;
        holdLeft = 0;
        nDBR = 1'b1;
        checks = checks + 1;
        if (isMiss) begin
            if (!quiet || taSeen) begin
                reportProblem({tag, ": bus cycle for an address outside register space"});
            end
        end else begin
            if (!taSeen) begin
                reportProblem({tag, ": access was never acknowledged with regTa"});
            end
            checks = checks + 1;
            if ({gotUds, gotLds} !== {vecUds[i], vecLds[i]}) begin
                reportMismatch({tag, " data strobes"}, {14'h0, vecUds[i], vecLds[i]},
                               {14'h0, gotUds, gotLds});
            end
            if (!isRead) begin
                checks = checks + 1;
                if (!oeSeen) begin
                    reportProblem({tag, ": write data was never driven"});
                end else if (oeBad) begin
                    reportMismatch({tag, " write data"}, vecWrite[i], oeValue);
                end
            end
        end
        checks = checks + 1;
        if (cpuReadData !== vecRead[i]) begin  // Writes and misses keep the last read
            reportMismatch({tag, " read data"}, vecRead[i], cpuReadData);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence

    initial begin
        int seedValue;
        int totalHolds;
        int i;
        seedValue = $urandom(32'h243d_d1e8);
        {nRESET, C1, C3, cpuCycle, casAgnus} = 5'b00000;
        {rnw, nDBR} = 2'b11;
        cpuAddr = 24'h0;
        siz = 2'b10;
        cpuWriteData = 16'h0;
        chipDataIn = 16'h0;
        {phase, holdLeft, checks, errors} = {32'd27, 32'd0, 32'd0, 32'd0};
        readGolden();
        totalHolds = 0;
        foreach (vecHolds[k]) begin
            totalHolds = totalHolds + vecHolds[k];
        end
        watchdogNs = (vecRnw.size() * 6 + totalHolds + 10) * 280;  // Colour clocks of 280 ns
        for (i = 0; i < 3; i++) begin
            nextCycle();
            checkIdleLevels("reset");
        end
        nRESET = 1'b1;
        nextCycle();
        checkIdleLevels("after reset");
        for (i = 0; i < vecRnw.size(); i++) begin
            runAccess(i);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/chipsetBridge_golden.txt
# rnw addr siz wdata holds chipdata nUDS nLDS readdata, all hex but holds in decimal
# holds is the count of C1 rising edges with nDBR low, nUDS nLDS both 1 means no bus cycle
1 DFF006 2 0000 0 A5C3 0 0 A5C3
0 DFF180 2 0FFF 0 0000 0 0 A5C3
0 DFF096 1 8281 0 0000 0 1 A5C3
0 DFF097 1 0020 0 0000 1 0 A5C3
1 DFF004 2 0000 2 1234 0 0 1234
0 DFF09A 2 C020 3 0000 0 0 1234
1 C00004 2 0000 0 FFFF 1 1 1234
0 BFE001 1 0003 0 0000 1 1 1234
1 DFF01F 1 0000 1 4020 0 0 4020
0 DFF0A8 2 0040 1 0000 0 0 4020
0 DFF09E 1 00AA 0 0000 0 1 4020
1 DFEFFE 2 0000 0 BEEF 1 1 4020
1 DFF002 2 0000 3 2400 0 0 2400
0 DFF100 2 1200 2 0000 0 0 2400
0 DFF181 1 0055 1 0000 1 0 2400
1 DFF010 2 0000 0 8000 0 0 8000
0 E00000 2 1111 0 0000 1 1 8000
1 DFF07C 1 0000 0 00F8 0 0 00F8
0 DFF1FF 1 0077 0 0000 1 0 00F8
0 DFF1FE 1 0066 2 0000 0 1 00F8
1 DFF018 2 0000 1 5A5A 0 0 5A5A
0 DFF034 2 FFFF 0 0000 0 0 5A5A

//--- testbench/chipsetBridge_sva.sv
////////////////////////////////////////
// Bus protocol assertions for the chipset register bridge
// Bound into every chipsetBridge instance
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module chipsetBridge_sva (
    input wire CLK40,
    input wire nRESET,
    input wire nAS,
    input wire nUDS,
    input wire nLDS,
    input wire regTa
);

    // Data strobes only inside an address strobe, so nAS falls first or together
    strobeOrder: assert property (@(posedge CLK40) disable iff (!nRESET)
        (!nUDS || !nLDS) |-> !nAS)
        else $error("Data strobe active while nAS is high");

    taWidth: assert property (@(posedge CLK40) disable iff (!nRESET)
        regTa |=> !regTa)
        else $error("regTa held for more than one clock");

    // Writes are acknowledged on the edge that negates nAS
    taInCycle: assert property (@(posedge CLK40) disable iff (!nRESET)
        regTa |-> (!nAS || $rose(nAS)))
        else $error("regTa outside a bus cycle");

endmodule

bind chipsetBridge chipsetBridge_sva chipsetBridge_sva_i (
    .CLK40  (CLK40),
    .nRESET (nRESET),
    .nAS    (nAS),
    .nUDS   (nUDS),
    .nLDS   (nLDS),
    .regTa  (regTa)
);

`default_nettype wire
